//--- rtl/quarkCfg.svh
// Quark core configuration macros: reset address, address width, register count
`ifndef QUARK_CFG_SVH
`define QUARK_CFG_SVH

// Address of the first instruction fetch after reset
`define QUARK_RESET_ADDR 32'h0000_0000

// Width of the program counter and of the internal address adders
// Upper address bits on the bus are driven as zero
`define QUARK_ADDR_WIDTH 24

// General registers, x0 included
`define QUARK_NUM_REGS 32

`endif

//--- rtl/quarkPkg.sv
// Quark package: word, address, register index, immediate, mask types and control states
`include "quarkCfg.svh"

package quarkPkg;

   typedef logic [31:0] word_t;                       // Data word on the bus and in registers
   typedef logic [`QUARK_ADDR_WIDTH-1:0] addr_t;      // Internal address, PC width
   typedef logic [4:0] regIdx_t;                      // Register index
   typedef logic [31:0] imm_t;                        // Sign extended immediate
   typedef logic [3:0] byteMask_t;                    // One bit per byte lane
   typedef logic [7:0] funct3Hot_t;                   // funct3Hot[n] set when funct3 == n

   // Multi-cycle control sequence
   typedef enum logic [1:0] {
      fetchInstr,    // Read strobe for the instruction
      waitInstr,     // Wait for the fetched word
      execute,       // Update PC, start memory access or shift
      waitAluOrMem   // Wait for shifter and memory to go idle
   } ctrlState_t;

endpackage

//--- rtl/decodeIf.sv
// Decoded instruction bundle from the instruction decoder to the execution blocks
interface decodeIf;

   quarkPkg::word_t      instruction;   // Latched instruction word
   quarkPkg::regIdx_t    rdId;          // Destination register
   quarkPkg::funct3Hot_t funct3Hot;

   // Immediates, all sign extended to 32 bits
   quarkPkg::imm_t immI;
   quarkPkg::imm_t immS;
   quarkPkg::imm_t immB;
   quarkPkg::imm_t immU;
   quarkPkg::imm_t immJ;

   // Instruction class, at most one set
   logic isLoad;
   logic isStore;
   logic isAluReg;
   logic isAluImm;
   logic isBranch;
   logic isJal;
   logic isJalr;
   logic isLui;
   logic isAuipc;

   logic subFlag;      // SUB rather than ADD
   logic arithShift;   // SRA rather than SRL

   modport decoder (
      output instruction, rdId, funct3Hot, immI, immS, immB, immU, immJ,
      output isLoad, isStore, isAluReg, isAluImm, isBranch, isJal, isJalr, isLui, isAuipc,
      output subFlag, arithShift
   );

   modport consumer (
      input instruction, rdId, funct3Hot, immI, immS, immB, immU, immJ,
      input isLoad, isStore, isAluReg, isAluImm, isBranch, isJal, isJalr, isLui, isAuipc,
      input subFlag, arithShift
   );

   modport regWrite (input rdId);

endinterface

//--- rtl/instrDecoder.sv
// Instruction register and decode of class, funct3 and the five immediate formats
module instrDecoder (
   input  logic            clk,
   input  logic            instrLoad,
   input  quarkPkg::word_t memRdata,
   decodeIf.decoder        dec
);

   import quarkPkg::*;

   logic [31:2] instrReg;   // Bits 1:0 are always 11 in RV32I
   logic [4:0]  opcode;

   // Latch the fetched word once the memory has it
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instrReg <= memRdata[31:2];
      end
   end

   assign opcode          = instrReg[6:2];
   assign dec.instruction = {instrReg, 2'b11};
   assign dec.rdId        = regIdx_t'(instrReg[11:7]);

   // One-hot funct3 keeps the ALU and branch muxes shallow
   assign dec.funct3Hot = funct3Hot_t'(8'b0000_0001 << instrReg[14:12]);

   // Immediate formats
   assign dec.immI = {{21{instrReg[31]}}, instrReg[30:20]};
   assign dec.immS = {{21{instrReg[31]}}, instrReg[30:25], instrReg[11:7]};
   assign dec.immB = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                      instrReg[11:8], 1'b0};
   assign dec.immU = {instrReg[31:12], 12'b0};
   assign dec.immJ = {{12{instrReg[31]}}, instrReg[19:12], instrReg[20],
                      instrReg[30:21], 1'b0};

   // Opcode classes
   assign dec.isLoad   = (opcode == 5'b00000);   // rd <- mem[rs1 + I]
   assign dec.isAluImm = (opcode == 5'b00100);   // rd <- rs1 op I
   assign dec.isAuipc  = (opcode == 5'b00101);   // rd <- PC + U
   assign dec.isStore  = (opcode == 5'b01000);   // mem[rs1 + S] <- rs2
   assign dec.isAluReg = (opcode == 5'b01100);   // rd <- rs1 op rs2
   assign dec.isLui    = (opcode == 5'b01101);   // rd <- U
   assign dec.isBranch = (opcode == 5'b11000);   // PC <- PC + B if taken
   assign dec.isJalr   = (opcode == 5'b11001);   // rd <- PC + 4, PC <- rs1 + I
   assign dec.isJal    = (opcode == 5'b11011);   // rd <- PC + 4, PC <- PC + J

   // Bit 30 selects SUB and SRA
   // Bit 5 keeps ADDI from looking like SUB, since its immediate overlaps bit 30
   assign dec.subFlag    = instrReg[30] & instrReg[5];
   assign dec.arithShift = instrReg[30];

endmodule

//--- rtl/registerFile.sv
// General register file with operand read at fetch and write-back port
`include "quarkCfg.svh"

module registerFile (
   input  logic            clk,
   input  logic            readEn,
   input  quarkPkg::word_t fetchWord,
   decodeIf.regWrite       dec,
   input  logic            writeEn,
   input  quarkPkg::word_t writeData,
   output quarkPkg::word_t rs1,
   output quarkPkg::word_t rs2
);

   import quarkPkg::*;

   word_t   regs [`QUARK_NUM_REGS];
   regIdx_t rs1Id;
   regIdx_t rs2Id;

   // Source indices come straight from the word being fetched
   assign rs1Id = fetchWord[19:15];
   assign rs2Id = fetchWord[24:20];

   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];   // x0 reads as zero
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

   always_ff @(posedge clk) begin
      if (writeEn && (dec.rdId != '0)) begin        // Writes to x0 dropped
         regs[dec.rdId] <= writeData;
      end
   end

endmodule

//--- rtl/aluShifter.sv
// ALU with shared compare subtractor, bit-serial shifter and branch predicate
module aluShifter (
   input  logic            clk,
   input  logic            mem_rstrb,
   input  logic            aluStart,
   decodeIf.consumer       dec,
   input  quarkPkg::word_t rs1,
   input  quarkPkg::word_t rs2,
   output quarkPkg::word_t aluOut,
   output quarkPkg::word_t aluPlus,
   output logic            aluBusy,
   output logic            branchTaken
);

   import quarkPkg::*;

   word_t       aluIn2;
   logic [32:0] aluMinus;   // Bit 32 is the borrow
   logic        lt;
   logic        ltu;
   logic        eq;
   logic        isShift;
   word_t       shiftReg;
   logic [4:0]  shamt;      // Remaining shift steps

   // Register operand for reg ops and branches, I-immediate for the rest
   assign aluIn2 = (dec.isAluReg || dec.isBranch) ? rs2 : dec.immI;

   assign aluPlus = rs1 + aluIn2;   // Also the JALR target

   // One subtract serves SUB, SLT, SLTU and all branch compares
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign ltu      = aluMinus[32];
   assign eq       = (aluMinus[31:0] == '0);

   assign isShift = dec.funct3Hot[1] | dec.funct3Hot[5];
   assign aluBusy = |shamt;

   always_comb begin
      aluOut = '0;
      case (1'b1)
         dec.funct3Hot[0]: aluOut = dec.subFlag ? aluMinus[31:0] : aluPlus;
         dec.funct3Hot[2]: aluOut = {31'b0, lt};
         dec.funct3Hot[3]: aluOut = {31'b0, ltu};
         dec.funct3Hot[4]: aluOut = rs1 ^ aluIn2;
         dec.funct3Hot[6]: aluOut = rs1 | aluIn2;
         dec.funct3Hot[7]: aluOut = rs1 & aluIn2;
         default:          aluOut = shiftReg;   // SLL, SRL, SRA
      endcase
   end

   // Shift count, cleared on reset so the core starts idle
   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         shamt <= '0;
      end else if (aluStart && isShift) begin
         shamt <= aluIn2[4:0];
      end else if (aluBusy) begin
         shamt <= shamt - 5'd1;
      end
   end

   // One bit per cycle, SRA refills from the sign bit
   always_ff @(posedge clk) begin
      if (aluStart && isShift) begin
         shiftReg <= rs1;
      end else if (aluBusy) begin
         if (dec.funct3Hot[1]) begin
            shiftReg <= {shiftReg[30:0], 1'b0};
         end else begin
            shiftReg <= {dec.arithShift & shiftReg[31], shiftReg[31:1]};
         end
      end
   end

   // Branch conditions by funct3
   assign branchTaken = (dec.funct3Hot[0] &  eq)  |   // BEQ
                        (dec.funct3Hot[1] & ~eq)  |   // BNE
                        (dec.funct3Hot[4] &  lt)  |   // BLT
                        (dec.funct3Hot[5] & ~lt)  |   // BGE
                        (dec.funct3Hot[6] &  ltu) |   // BLTU
                        (dec.funct3Hot[7] & ~ltu);    // BGEU

endmodule

//--- rtl/loadStoreUnit.sv
// Load/store address adder, load alignment and extension, store lane steering and mask
`include "quarkCfg.svh"

module loadStoreUnit (
   decodeIf.consumer           dec,
   input  quarkPkg::word_t     rs1,
   input  quarkPkg::word_t     rs2,
   input  quarkPkg::word_t     memRdata,
   output quarkPkg::addr_t     lsAddr,
   output quarkPkg::word_t     loadData,
   output quarkPkg::byteMask_t storeMask,
   output quarkPkg::word_t     storeData
);

   import quarkPkg::*;

   addr_t       addrOffset;
   logic        byteAccess;
   logic        halfAccess;
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   // S-immediate for stores, I-immediate for loads
   assign addrOffset = dec.isStore ? dec.immS[`QUARK_ADDR_WIDTH-1:0]
                                   : dec.immI[`QUARK_ADDR_WIDTH-1:0];
   assign lsAddr = rs1[`QUARK_ADDR_WIDTH-1:0] + addrOffset;

   // funct3[1:0] gives the size, funct3[2] marks unsigned loads
   assign byteAccess = (dec.instruction[13:12] == 2'b00);
   assign halfAccess = (dec.instruction[13:12] == 2'b01);

   // Pick the addressed halfword, then the byte within it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~dec.instruction[14] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Replicate low byte and halfword so any lane sees the right data
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2[7:0] :
                             lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = byteMask_t'(4'b0001 << lsAddr[1:0]);   // One lane
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;         // Low or high pair
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

//--- rtl/executeControl.sv
// Control FSM, program counter, next-PC select, write-back select and bus strobes
`include "quarkCfg.svh"

module executeControl (
   input  logic                clk,
   input  logic                mem_rstrb,
   decodeIf.consumer           dec,
   input  logic                memRbusy,
   input  logic                memWbusy,
   input  logic                aluBusy,
   input  logic                branchTaken,
   input  quarkPkg::word_t     aluOut,
   input  quarkPkg::word_t     aluPlus,
   input  quarkPkg::addr_t     lsAddr,
   input  quarkPkg::word_t     loadData,
   input  quarkPkg::byteMask_t storeMask,
   output logic                instrLoad,
   output logic                aluStart,
   output logic                regWriteEn,
   output quarkPkg::word_t     writeData,
   output quarkPkg::word_t     memAddr,
   output logic                memReadStrobe,
   output quarkPkg::byteMask_t memWmask
);

   import quarkPkg::*;

   localparam word_t ResetAddr = `QUARK_RESET_ADDR;

   ctrlState_t state;
   addr_t      pc;
   addr_t      pcPlus4;
   addr_t      pcPlusImm;
   addr_t      nextPc;
   logic       isAlu;
   logic       isShift;
   logic       needToWait;
   logic       jumpToImm;

   assign isAlu      = dec.isAluReg | dec.isAluImm;
   assign isShift    = dec.funct3Hot[1] | dec.funct3Hot[5];
   assign needToWait = dec.isLoad | dec.isStore | (isAlu & isShift);
   assign jumpToImm  = dec.isJal | (dec.isBranch & branchTaken);

   assign pcPlus4 = pc + addr_t'(4);

   // Shared adder for JAL, AUIPC and branch targets
   assign pcPlusImm = pc + (dec.isJal   ? dec.immJ[`QUARK_ADDR_WIDTH-1:0] :
                            dec.isAuipc ? dec.immU[`QUARK_ADDR_WIDTH-1:0] :
                                          dec.immB[`QUARK_ADDR_WIDTH-1:0]);

   assign nextPc = dec.isJalr ? {aluPlus[`QUARK_ADDR_WIDTH-1:1], 1'b0} :   // Bit 0 cleared
                   jumpToImm  ? pcPlusImm :
                                pcPlus4;

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= waitAluOrMem;   // Wait for a pending write first
         pc    <= ResetAddr[`QUARK_ADDR_WIDTH-1:0];
      end else begin
         case (state)
            fetchInstr: begin
               state <= waitInstr;
            end
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               pc    <= nextPc;
               state <= needToWait ? waitAluOrMem : fetchInstr;
            end
            default: begin   // waitAluOrMem
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

   // Strobes decoded from the state
   assign instrLoad  = (state == waitInstr) & ~memRbusy;
   assign aluStart   = (state == execute) & isAlu;
   assign regWriteEn = ((state == execute) | (state == waitAluOrMem)) &
                       ~(dec.isBranch | dec.isStore);

   assign memReadStrobe = (state == fetchInstr) | ((state == execute) & dec.isLoad);
   assign memWmask      = {4{(state == execute) & dec.isStore}} & storeMask;

   // PC during fetch, data address otherwise
   assign memAddr = ((state == fetchInstr) || (state == waitInstr)) ? word_t'(pc)
                                                                    : word_t'(lsAddr);

   // Class flags are exclusive, so an OR of gated sources is enough
   assign writeData = (dec.isLui                ? dec.immU          : '0) |
                      (isAlu                    ? aluOut            : '0) |
                      (dec.isAuipc              ? word_t'(pcPlusImm) : '0) |
                      ((dec.isJal | dec.isJalr) ? word_t'(pcPlus4)   : '0) |
                      (dec.isLoad               ? loadData          : '0);

endmodule

//--- rtl/quarkCore.sv
// Quark RV32I multi-cycle core top level with a single memory bus
module quarkCore (
   input  logic                clk,
   input  logic                mem_rstrb,
   output quarkPkg::word_t     memAddr,
   output quarkPkg::word_t     memWdata,
   output quarkPkg::byteMask_t memWmask,
   output logic                memReadStrobe,
   input  quarkPkg::word_t     memRdata,
   input  logic                memRbusy,
   input  logic                memWbusy
);

   import quarkPkg::*;

   // Control strobes
   logic instrLoad;
   logic aluStart;
   logic regWriteEn;

   // Datapath
   word_t     writeData;
   word_t     rs1;
   word_t     rs2;
   word_t     aluOut;
   word_t     aluPlus;
   logic      aluBusy;
   logic      branchTaken;
   addr_t     lsAddr;
   word_t     loadData;
   byteMask_t storeMask;

   decodeIf decodeIf_inst ();

   instrDecoder instrDecoder_inst (
      .clk       (clk),
      .instrLoad (instrLoad),
      .memRdata  (memRdata),
      .dec       (decodeIf_inst.decoder)
   );

   // Operands are read from the word on the bus while it is latched
   registerFile registerFile_inst (
      .clk       (clk),
      .readEn    (instrLoad),
      .fetchWord (memRdata),
      .dec       (decodeIf_inst.regWrite),
      .writeEn   (regWriteEn),
      .writeData (writeData),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   aluShifter aluShifter_inst (
      .clk         (clk),
      .mem_rstrb   (mem_rstrb),
      .aluStart    (aluStart),
      .dec         (decodeIf_inst.consumer),
      .rs1         (rs1),
      .rs2         (rs2),
      .aluOut      (aluOut),
      .aluPlus     (aluPlus),
      .aluBusy     (aluBusy),
      .branchTaken (branchTaken)
   );

   loadStoreUnit loadStoreUnit_inst (
      .dec       (decodeIf_inst.consumer),
      .rs1       (rs1),
      .rs2       (rs2),
      .memRdata  (memRdata),
      .lsAddr    (lsAddr),
      .loadData  (loadData),
      .storeMask (storeMask),
      .storeData (memWdata)   // Lanes already steered
   );

   executeControl executeControl_inst (
      .clk           (clk),
      .mem_rstrb     (mem_rstrb),
      .dec           (decodeIf_inst.consumer),
      .memRbusy      (memRbusy),
      .memWbusy      (memWbusy),
      .aluBusy       (aluBusy),
      .branchTaken   (branchTaken),
      .aluOut        (aluOut),
      .aluPlus       (aluPlus),
      .lsAddr        (lsAddr),
      .loadData      (loadData),
      .storeMask     (storeMask),
      .instrLoad     (instrLoad),
      .aluStart      (aluStart),
      .regWriteEn    (regWriteEn),
      .writeData     (writeData),
      .memAddr       (memAddr),
      .memReadStrobe (memReadStrobe),
      .memWmask      (memWmask)
   );

endmodule

//--- bench/quarkCoreTb.sv
// Testbench for quarkCore: memory model, test program, busy stimulus, assertions, report
`include "quarkCfg.svh"

module quarkCoreTb;

   import quarkPkg::*;

   localparam word_t ResultBase = 32'h0000_0800;   // Result slots, one word each
   localparam word_t DataBase   = 32'h0000_0700;   // Load pattern
   localparam word_t Pattern    = 32'hF180_7F05;
   localparam int    NumSlots   = 64;

   logic      clk = 1'b0;
   logic      mem_rstrb;
   word_t     memAddr;
   word_t     memWdata;
   byteMask_t memWmask;
   logic      memReadStrobe;
   word_t     memRdata;
   logic      memRbusy;
   logic      memWbusy;

   word_t     mem [1024];          // 4 KB word memory
   word_t     readAddr;
   int        rCnt;
   int        wCnt;
   int        pcIdx;
   int        nextSlot;
   int        doneSlot;
   word_t     expData [NumSlots];
   byteMask_t expMask [NumSlots];
   int        expGroup [NumSlots];
   int        writeCount [NumSlots];
   int        groupFails [1:6];
   int        groupChecks [1:6];
   int        errorCount;
   logic      fetchSeen;
   logic      inResult;
   int        slotIdx;
   word_t     laneBits;

   quarkCore quarkCore_inst (.*);

   always #4 clk = ~clk;           // 8 unit period

   // Read data follows the address latched with the strobe
   assign memRdata = mem[readAddr[11:2]];
   assign inResult = (memAddr >= ResultBase) && (memAddr < ResultBase + NumSlots * 4);
   assign slotIdx  = int'((memAddr - ResultBase) >> 2);
   assign laneBits = {{8{memWmask[3]}}, {8{memWmask[2]}}, {8{memWmask[1]}}, {8{memWmask[0]}}};

   always @(posedge clk) begin
      if (memReadStrobe) readAddr <= memAddr;
      for (int i = 0; i < 4; i++) begin
         if (memWmask[i]) mem[memAddr[11:2]][8*i +: 8] <= memWdata[8*i +: 8];
      end
      if (!mem_rstrb && memReadStrobe) fetchSeen <= 1'b1;
      if (!mem_rstrb && (memWmask != '0) && inResult) begin
         writeCount[slotIdx] <= writeCount[slotIdx] + 1;
      end
   end

   // Busy stretches of 0 to 3 cycles after each read strobe and each write
   task automatic driveBusy();
      int unsigned n;
      forever begin
         @(posedge clk);
         if (mem_rstrb) begin
            rCnt     <= 0;
            wCnt     <= 0;
            memRbusy <= 1'b0;
            memWbusy <= 1'b0;
         end else begin
            if (memReadStrobe) begin
               n = $urandom % 4;
               rCnt     <= n;
               memRbusy <= (n != 0);
            end else if (rCnt != 0) begin
               rCnt     <= rCnt - 1;
               memRbusy <= (rCnt > 1);
            end
            if (memWmask != '0) begin
               n = $urandom % 4;
               wCnt     <= n;
               memWbusy <= (n != 0);
            end else if (wCnt != 0) begin
               wCnt     <= wCnt - 1;
               memWbusy <= (wCnt > 1);
            end
         end
      end
   endtask

   task automatic noteFailure(input int g);
      errorCount++;
      groupFails[g]++;
   endtask

   // First fetch comes from the reset address, no write before it
   assert property (@(posedge clk) disable iff (mem_rstrb)
         (!fetchSeen && memReadStrobe) |-> (memAddr == `QUARK_RESET_ADDR))
      else begin
         $display("Mismatch at %0t: first fetch from %h", $time, $sampled(memAddr));
         noteFailure(1);
      end
   assert property (@(posedge clk) disable iff (mem_rstrb) !fetchSeen |-> (memWmask == '0))
      else begin
         $display("Write strobe seen before the first fetch at %0t", $time);
         noteFailure(1);
      end

   // Core must hold off writes while the memory is busy
   assert property (@(posedge clk) disable iff (mem_rstrb) memWbusy |-> (memWmask == '0))
      else begin
         $display("Write issued while memWbusy was high at %0t", $time);
         noteFailure(6);
      end

   // Each result write against the expected lanes and mask
   assert property (@(posedge clk) disable iff (mem_rstrb)
         ((memWmask != '0) && inResult) |->
         ((memWmask == expMask[slotIdx]) && (((memWdata ^ expData[slotIdx]) & laneBits) == '0)))
      else begin
         $display("Mismatch at %0t: slot %0d got %h mask %b, expected %h mask %b", $time,
                  $sampled(slotIdx), $sampled(memWdata), $sampled(memWmask),
                  expData[$sampled(slotIdx)], expMask[$sampled(slotIdx)]);
         noteFailure(expGroup[$sampled(slotIdx)]);
      end

   // Instruction encoders
   function automatic word_t encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                  logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t encJ(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic emit(input word_t w);
      mem[pcIdx] = w;
      pcIdx++;
   endtask

   // LUI plus ADDI, upper part rounded for the signed low part
   task automatic loadImm(input logic [4:0] rd, input word_t v);
      word_t hi;
      hi = (v + 32'h800) >> 12;
      emit({hi[19:0], rd, 7'b0110111});
      emit(encI(v[11:0], rd, 3'b000, rd, 7'b0010011));
   endtask

   task automatic recordExpect(input int slot, input word_t d, input byteMask_t m, input int g);
      expData[slot]  = d;
      expMask[slot]  = m;
      expGroup[slot] = g;
      groupChecks[g]++;
   endtask

   task automatic storeResult(input logic [4:0] rs2, input word_t d, input int g);
      emit(encS(12'(nextSlot * 4), rs2, 5'd31, 3'b010));
      recordExpect(nextSlot, d, 4'b1111, g);
      nextSlot++;
   endtask

   // SB or SH of x16 at a byte offset inside a fresh slot
   task automatic storeLanes(input word_t v, input int off, input bit half);
      emit(encS(12'(nextSlot * 4 + off), 5'd16, 5'd31, half ? 3'b001 : 3'b000));
      if (half) recordExpect(nextSlot, {2{v[15:0]}}, (off == 2) ? 4'b1100 : 4'b0011, 4);
      else      recordExpect(nextSlot, {4{v[7:0]}}, byteMask_t'(4'b0001 << off), 4);
      nextSlot++;
   endtask

   task automatic loadCheck(input logic [2:0] f3, input int off, input word_t d);
      emit(encI(12'(off), 5'd17, f3, 5'd18, 7'b0000011));
      storeResult(5'd18, d, 4);
   endtask

   // Taken branch skips a bad marker into the same slot
   task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input bit taken);
      emit(encB(13'd8, rs2, rs1, f3));
      if (taken) emit(encS(12'(nextSlot * 4), 5'd21, 5'd31, 3'b010));
      storeResult(5'd20, 32'h600D, 5);
   endtask

   task automatic buildProgram();
      word_t a;
      word_t b;
      word_t c;
      word_t sv;
      word_t t;
      int    sh [3];
      a  = 32'h1234_5678;
      b  = 32'hFFFF_FFF0;          // -16
      c  = 32'd5;
      sv = 32'h8000_0001;
      sh = '{0, 1, 31};
      loadImm(31, ResultBase);
      loadImm(1, a);
      loadImm(2, b);
      loadImm(3, c);
      emit(encR(7'h00, 2, 1, 3'b000, 4));                  // ADD
      storeResult(4, a + b, 2);
      emit(encR(7'h20, 2, 1, 3'b000, 4));                  // SUB
      storeResult(4, a - b, 2);
      emit(encI(12'hFF9, 3, 3'b000, 4, 7'b0010011));       // ADDI -7
      storeResult(4, c - 7, 2);
      emit(encR(7'h00, 3, 2, 3'b010, 4));                  // SLT
      storeResult(4, word_t'($signed(b) < $signed(c)), 2);
      emit(encR(7'h00, 3, 2, 3'b011, 4));                  // SLTU
      storeResult(4, word_t'(b < c), 2);
      emit(encR(7'h00, 2, 1, 3'b100, 4));
      storeResult(4, a ^ b, 2);
      emit(encR(7'h00, 3, 1, 3'b110, 4));
      storeResult(4, a | c, 2);
      emit(encR(7'h00, 2, 1, 3'b111, 4));
      storeResult(4, a & b, 2);
      loadImm(12, sv);
      foreach (sh[i]) begin
         emit(encI(12'(sh[i]), 12, 3'b001, 14, 7'b0010011));           // SLLI
         storeResult(14, sv << sh[i], 3);
         emit(encI(12'(sh[i]), 12, 3'b101, 14, 7'b0010011));           // SRLI
         storeResult(14, sv >> sh[i], 3);
         emit(encI(12'h400 | 12'(sh[i]), 12, 3'b101, 14, 7'b0010011)); // SRAI
         storeResult(14, word_t'($signed(sv) >>> sh[i]), 3);
      end
      loadImm(13, 32'd4);
      emit(encR(7'h00, 13, 12, 3'b001, 14));               // SLL by register
      storeResult(14, sv << 4, 3);
      emit(encR(7'h20, 13, 12, 3'b101, 14));               // SRA by register
      storeResult(14, word_t'($signed(sv) >>> 4), 3);
      t = 32'hA1B2_C3D4;
      loadImm(16, t);
      for (int off = 0; off < 4; off++) storeLanes(t, off, 1'b0);
      storeLanes(t, 0, 1'b1);
      storeLanes(t, 2, 1'b1);
      loadImm(17, DataBase);
      loadCheck(3'b000, 1, {{24{Pattern[15]}}, Pattern[15:8]});    // LB positive
      loadCheck(3'b000, 2, {{24{Pattern[23]}}, Pattern[23:16]});   // LB negative
      loadCheck(3'b000, 3, {{24{Pattern[31]}}, Pattern[31:24]});
      loadCheck(3'b100, 2, {24'b0, Pattern[23:16]});               // LBU
      loadCheck(3'b001, 0, {{16{Pattern[15]}}, Pattern[15:0]});    // LH
      loadCheck(3'b001, 2, {{16{Pattern[31]}}, Pattern[31:16]});
      loadCheck(3'b101, 2, {16'b0, Pattern[31:16]});               // LHU
      loadCheck(3'b010, 0, Pattern);                               // LW
      loadImm(20, 32'h600D);       // Good path marker
      loadImm(21, 32'hBAD);        // Wrong path marker
      branchCase(3'b000, 3, 3, 1'b1);   // BEQ
      branchCase(3'b000, 1, 3, 1'b0);
      branchCase(3'b001, 1, 3, 1'b1);   // BNE
      branchCase(3'b001, 3, 3, 1'b0);
      branchCase(3'b100, 2, 3, 1'b1);   // BLT -16 < 5
      branchCase(3'b100, 3, 2, 1'b0);
      branchCase(3'b101, 3, 2, 1'b1);   // BGE
      branchCase(3'b101, 2, 3, 1'b0);
      branchCase(3'b110, 3, 2, 1'b1);   // BLTU 5 < 0xFFFFFFF0
      branchCase(3'b110, 2, 3, 1'b0);
      branchCase(3'b111, 2, 3, 1'b1);   // BGEU
      branchCase(3'b111, 3, 2, 1'b0);
      t = word_t'(pcIdx * 4);
      emit(encJ(21'd8, 22));                               // JAL over a bad store
      emit(encS(12'(nextSlot * 4), 21, 31, 3'b010));
      storeResult(22, t + 4, 5);
      t = word_t'((pcIdx + 2) * 4);                        // Address of the JALR
      loadImm(23, t + 6);
      emit(encI(12'd3, 23, 3'b000, 24, 7'b1100111));       // Odd sum, bit 0 dropped
      emit(encS(12'(nextSlot * 4), 21, 31, 3'b010));
      storeResult(24, t + 4, 5);
      emit({20'hABCDE, 5'd25, 7'b0110111});                // LUI
      storeResult(25, 32'hABCD_E000, 5);
      t = word_t'(pcIdx * 4);
      emit({20'h00001, 5'd26, 7'b0010111});                // AUIPC
      storeResult(26, t + 32'h1000, 5);
      emit(encI(12'd123, 0, 3'b000, 0, 7'b0010011));       // Write to x0
      storeResult(0, 32'h0, 5);
      loadImm(27, 32'hD0E5);
      doneSlot = nextSlot;
      storeResult(27, 32'hD0E5, 6);
      emit(encJ(21'd0, 0));                                // Park in a loop
   endtask

   // Run ends here if the final store never arrives
   task automatic watchdog();
      #(pcIdx * 45 * 20 * 8);
      $display("Watchdog expired before the final result store");
      $display("Some tests failed");
      $finish;
   endtask

   initial begin
      string names [1:6];
      int    checks;
      int    seed;
      names = '{"Reset", "ALU operations", "Shifts", "Byte and halfword access",
                "Control flow", "Back-pressure"};
      seed       = $urandom(32'h9bad7673);
      mem_rstrb  = 1'b1;
      memRbusy   = 1'b0;
      memWbusy   = 1'b0;
      readAddr   = '0;
      fetchSeen  = 1'b0;
      rCnt       = 0;
      wCnt       = 0;
      pcIdx      = 0;
      nextSlot   = 0;
      errorCount = 0;
      for (int i = 0; i < 1024; i++) mem[i] = {i[15:0], ~i[15:0]};   // Address-dependent fill
      for (int i = 0; i < NumSlots; i++) begin
         expMask[i]    = '0;
         expGroup[i]   = 6;
         writeCount[i] = 0;
      end
      for (int g = 1; g <= 6; g++) begin
         groupFails[g]  = 0;
         groupChecks[g] = 0;
      end
      groupChecks[1] = 1;
      groupChecks[6] = 1;
      mem[DataBase[11:2]] = Pattern;
      buildProgram();
      fork
         watchdog();
         driveBusy();
      join_none
      repeat (5) @(posedge clk);
      mem_rstrb <= 1'b0;
      wait (writeCount[doneSlot] != 0);
      repeat (4) @(posedge clk);
      for (int s = 0; s < nextSlot; s++) begin
         assert (writeCount[s] == 1)
            else begin
               $display("Result slot %0d written %0d times instead of once", s, writeCount[s]);
               noteFailure(expGroup[s]);
            end
      end
      checks = 0;
      for (int g = 1; g <= 6; g++) begin
         $display("%s: %0d checks, %0d failures", names[g], groupChecks[g], groupFails[g]);
         checks += groupChecks[g];
      end
      $display("Passed: %0d, failed: %0d", (checks > errorCount) ? checks - errorCount : 0,
               errorCount);
      if (errorCount == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+rtl
rtl/quarkPkg.sv
rtl/decodeIf.sv
rtl/instrDecoder.sv
rtl/registerFile.sv
rtl/aluShifter.sv
rtl/loadStoreUnit.sv
rtl/executeControl.sv
rtl/quarkCore.sv
bench/quarkCoreTb.sv
